//--- source/active_list_config.svh
`ifndef ACTIVE_LIST_CONFIG_SVH
`define ACTIVE_LIST_CONFIG_SVH

// Number of mapping entries in the active list, one per in-flight remapping
`define AL_DEPTH 32

// Result queue slots that hold write-back data until commit
`define DQ_DEPTH 8

`define DATA_WIDTH 32 // Width of a result word

// Logical and physical register addresses share this width
`define REG_WIDTH 6

`endif

//--- source/active_list_pkg.sv
`include "active_list_config.svh"

package active_list_pkg;

  // Tag handed to an instruction, also the index into the mapping table
  typedef logic [$clog2(`AL_DEPTH)-1:0] al_index_t;

  typedef logic [$clog2(`DQ_DEPTH)-1:0] dq_index_t; // Result queue slot

  typedef logic [`REG_WIDTH-1:0] reg_addr_t; // Logical or physical register

  typedef logic [`DATA_WIDTH-1:0] data_t; // Result word

  // One remapping, sent in at allocation and sent back on a flush
  typedef struct packed {
    reg_addr_t logical;  // Architectural register that was renamed
    reg_addr_t physical; // Physical register it pointed to
  } map_pair_t;

  // Result coming back from an execution unit
  typedef struct packed {
    al_index_t tag;  // Active list entry that produced it
    data_t     data;
  } wb_result_t;

  // Write request toward the register file at commit
  typedef struct packed {
    reg_addr_t physical; // Destination register
    data_t     data;     // Value to write
  } commit_t;

endpackage

//--- source/slot_encoder.sv
`timescale 1ns/10ps

module slot_encoder #(
  parameter int NUM_SLOTS = 8
) (
  input  logic [NUM_SLOTS-1:0]                                 slot_busy,
  output logic [((NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1)-1:0] free_slot,
  output logic                                                 all_busy
);

  // A single slot still needs a one bit index
  localparam int IDX_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

  // Scan from the top down so the lowest free slot is the last one to win
  always_comb begin
    free_slot = '0; // Slot zero when everything is busy, the caller checks all_busy
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (!slot_busy[i]) begin
        free_slot = IDX_W'(i);
      end
    end
  end

  // No free slot at all
  assign all_busy = &slot_busy;

endmodule

//--- source/result_queue.sv
`timescale 1ns/10ps
`include "active_list_config.svh"

module result_queue (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wb_write,    // Accepted write-back this cycle
  input  active_list_pkg::data_t     wb_data,     // Result to store
  input  active_list_pkg::dq_index_t commit_slot, // Slot of the head entry
  input  logic                       retire,      // Head entry leaves, free its slot
  input  logic                       queue_clear, // Flush start drops every result
  output active_list_pkg::dq_index_t write_slot,  // Slot taken by this write-back
  output active_list_pkg::data_t     commit_data, // Data for the committing entry
  output logic                       queue_full
);
  import active_list_pkg::*;

  data_t               slot_data [`DQ_DEPTH]; // Stored results
  logic [`DQ_DEPTH-1:0] slot_busy;             // Slot holds an uncommitted result
  logic [`DQ_DEPTH-1:0] busy_next;
  dq_index_t            free_slot;
  logic                 all_busy;

  // Lowest free slot gets the next result
  slot_encoder #(
    .NUM_SLOTS (`DQ_DEPTH)
  ) u_slot_encoder (
    .slot_busy (slot_busy),
    .free_slot (free_slot),
    .all_busy  (all_busy)
  );

  assign write_slot = free_slot;
  assign queue_full = all_busy; // Every slot waits for its entry to commit

  // Next busy mask
  // The committing slot is busy while the chosen write slot is free, so the
  // two updates never touch the same bit
  always_comb begin
    busy_next = slot_busy;
    if (retire) begin
      busy_next[commit_slot] = 1'b0;
    end
    if (wb_write) begin
      busy_next[free_slot] = 1'b1;
    end
    if (queue_clear) begin
      busy_next = '0; // A flush throws away every pending result
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_busy <= '0;
    end else begin
      slot_busy <= busy_next;
    end
  end

  // Result words themselves
  always_ff @(posedge clk) begin
    if (wb_write) begin
      slot_data[free_slot] <= wb_data;
    end
  end

  // The head entry's queue tag points straight at its result
  assign commit_data = slot_data[commit_slot];

endmodule

//--- source/mapping_table.sv
`timescale 1ns/10ps
`include "active_list_config.svh"

module mapping_table (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        add_mapping,  // New remapping at the tail
  input  active_list_pkg::map_pair_t  alloc_pair,
  input  logic                        wb_valid,     // Result arrives from execution
  input  active_list_pkg::wb_result_t wb_result,
  input  active_list_pkg::dq_index_t  write_slot,   // Queue slot picked for that result
  input  active_list_pkg::data_t      commit_data,  // Result of the head entry
  input  logic                        commit_ack,   // Register file took the commit
  input  logic                        flush,
  input  logic                        queue_full,
  output active_list_pkg::al_index_t  alloc_tag,
  output logic                        wb_write,
  output active_list_pkg::dq_index_t  commit_slot,
  output logic                        retire,
  output logic                        queue_clear,
  output logic                        commit_valid,
  output active_list_pkg::commit_t    commit,
  output logic                        restore_valid,
  output active_list_pkg::map_pair_t  restore_pair,
  output logic                        flush_busy
);
  import active_list_pkg::*;

  // One extra bit so a completely full list is not mistaken for an empty one
  localparam int CNT_W = $clog2(`AL_DEPTH) + 1;

  typedef enum logic {
    FLUSH_IDLE, // Normal operation
    FLUSH_WALK  // Stepping the tail back and replaying pairs
  } flush_state_t;

  map_pair_t            pair_mem [`AL_DEPTH]; // Remapping per entry
  dq_index_t            qtag_mem [`AL_DEPTH]; // Where each entry's result sits
  logic [`AL_DEPTH-1:0] done;                 // Entry has its result in the queue
  al_index_t            head;                 // Oldest uncommitted entry
  al_index_t            tail;                 // Next free entry
  al_index_t            tail_prev;            // Newest entry, the one a flush replays next
  logic [CNT_W-1:0]     entry_count;          // Entries between head and tail
  logic [CNT_W-1:0]     count_next;
  flush_state_t         flush_state;
  logic                 alloc_accept;
  logic                 walk_step;
  logic                 list_empty;

  assign flush_busy = (flush_state == FLUSH_WALK);
  assign list_empty = (entry_count == '0);
  assign tail_prev  = tail - 1'b1; // Wraps around with a power of two depth

  // Strobes that arrive during a flush are dropped
  assign alloc_accept = add_mapping && !flush_busy;
  assign wb_write     = wb_valid && !flush_busy && !queue_full; // No slot means no write
  assign queue_clear  = flush && !flush_busy; // Only the first flush pulse counts

  // Tag for an instruction allocated this cycle
  assign alloc_tag = tail;

  // Head entry goes out once its result is back
  assign commit_valid    = !list_empty && !flush_busy && done[head];
  assign commit_slot     = qtag_mem[head];
  assign commit.physical = pair_mem[head].physical;
  assign commit.data     = commit_data;
  assign retire          = commit_ack && commit_valid; // Ack without a valid commit is ignored

  // Each walk cycle hands one discarded pair back, newest first
  assign walk_step     = flush_busy && !list_empty;
  assign restore_valid = walk_step;
  assign restore_pair  = pair_mem[tail_prev];

  // Occupancy
  // The walk never overlaps allocation or retire because both are blocked while busy
  always_comb begin
    count_next = entry_count;
    if (alloc_accept) begin
      count_next = count_next + 1'b1;
    end
    if (retire || walk_step) begin
      count_next = count_next - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head        <= '0;
      tail        <= '0;
      entry_count <= '0;
      done        <= '0;
      flush_state <= FLUSH_IDLE;
    end else begin
      entry_count <= count_next;
      if (retire) begin
        head <= head + 1'b1; // Oldest entry leaves the list
      end
      if (walk_step) begin
        tail <= tail_prev;
      end else if (alloc_accept) begin
        tail <= tail + 1'b1;
      end
      if (alloc_accept) begin
        done[tail] <= 1'b0; // A fresh entry still waits for its result
      end
      if (wb_write) begin
        done[wb_result.tag] <= 1'b1;
      end
      case (flush_state)
        FLUSH_IDLE: begin
          if (flush) begin
            flush_state <= FLUSH_WALK;
          end
        end
        FLUSH_WALK: begin
          // Leave one cycle after the tail has met the head
          if (list_empty) begin
            flush_state <= FLUSH_IDLE;
          end
        end
        default: flush_state <= FLUSH_IDLE;
      endcase
    end
  end

  // Entry payload, valid only between head and tail
  always_ff @(posedge clk) begin
    if (alloc_accept) begin
      pair_mem[tail] <= alloc_pair;
    end
    if (wb_write) begin
      qtag_mem[wb_result.tag] <= write_slot; // Remember the slot for the commit lookup
    end
  end

endmodule

//--- source/active_list.sv
`timescale 1ns/10ps

module active_list (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        add_mapping,   // Rename stage remapped a register
  input  active_list_pkg::map_pair_t  alloc_pair,
  output active_list_pkg::al_index_t  alloc_tag,     // Tag of the entry added this cycle
  input  logic                        wb_valid,
  input  active_list_pkg::wb_result_t wb_result,
  input  logic                        commit_ack,    // Register file wrote the commit
  input  logic                        flush,
  output logic                        commit_valid,
  output active_list_pkg::commit_t    commit,
  output logic                        restore_valid, // Pair going back to the map table
  output active_list_pkg::map_pair_t  restore_pair,
  output logic                        flush_busy,
  output logic                        dq_full        // Hold off write-backs while high
);
  import active_list_pkg::*;

  logic      wb_write;
  logic      retire;
  logic      queue_clear;
  dq_index_t write_slot;
  dq_index_t commit_slot;
  data_t     commit_data;

  // In-order list of mappings, commit and flush control
  mapping_table u_mapping_table (
    .clk           (clk),
    .rst_n         (rst_n),
    .add_mapping   (add_mapping),
    .alloc_pair    (alloc_pair),
    .wb_valid      (wb_valid),
    .wb_result     (wb_result),
    .write_slot    (write_slot),
    .commit_data   (commit_data),
    .commit_ack    (commit_ack),
    .flush         (flush),
    .queue_full    (dq_full),
    .alloc_tag     (alloc_tag),
    .wb_write      (wb_write),
    .commit_slot   (commit_slot),
    .retire        (retire),
    .queue_clear   (queue_clear),
    .commit_valid  (commit_valid),
    .commit        (commit),
    .restore_valid (restore_valid),
    .restore_pair  (restore_pair),
    .flush_busy    (flush_busy)
  );

  // Results wait here until their entry commits
  result_queue u_result_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_write    (wb_write),
    .wb_data     (wb_result.data),
    .commit_slot (commit_slot),
    .retire      (retire),
    .queue_clear (queue_clear),
    .write_slot  (write_slot),
    .commit_data (commit_data),
    .queue_full  (dq_full)
  );

endmodule

//--- verification/active_list_tb.sv
`timescale 1ns/10ps
`include "active_list_config.svh"

module active_list_tb;
  import active_list_pkg::*;

  localparam int NUM_CYCLES   = 4000;
  localparam int WALK_TIMEOUT = `AL_DEPTH + 8; // Longest legal walk is AL_DEPTH + 1 cycles

  // One allocated instruction as the model sees it
  typedef struct packed {
    al_index_t tag;
    map_pair_t pair;
    logic      done; // Result has been written back
    data_t     data;
  } model_entry_t;

  logic       clk;
  logic       rst_n;
  logic       add_mapping;
  map_pair_t  alloc_pair;
  al_index_t  alloc_tag;
  logic       wb_valid;
  wb_result_t wb_result;
  logic       commit_ack;
  logic       flush;
  logic       commit_valid;
  commit_t    commit;
  logic       restore_valid;
  map_pair_t  restore_pair;
  logic       flush_busy;
  logic       dq_full;

  model_entry_t model_q[$];   // Uncommitted entries, oldest first
  map_pair_t    restore_q[$]; // Pairs the running flush must send back, newest first
  al_index_t    model_head;   // Tag of the oldest entry
  al_index_t    model_tail;   // Tag the next allocation gets
  integer       seed;
  int           error_count;
  int           check_count;
  int           flush_count;
  logic         timed_out;

  active_list uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .add_mapping   (add_mapping),
    .alloc_pair    (alloc_pair),
    .alloc_tag     (alloc_tag),
    .wb_valid      (wb_valid),
    .wb_result     (wb_result),
    .commit_ack    (commit_ack),
    .flush         (flush),
    .commit_valid  (commit_valid),
    .commit        (commit),
    .restore_valid (restore_valid),
    .restore_pair  (restore_pair),
    .flush_busy    (flush_busy),
    .dq_full       (dq_full)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk; // 100 ns period

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    error_count++;
    $display("ERROR %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
  endtask

  // Written-back results still waiting in the queue
  function automatic int count_done();
    int n;
    n = 0;
    foreach (model_q[i]) begin
      if (model_q[i].done) n++;
    end
    return n;
  endfunction

  // All outputs depend on state only, so they are steady a few ns after the edge
  task automatic check_outputs();
    logic exp_valid;
    logic exp_full;
    exp_valid = 1'b0;
    if (model_q.size() > 0) exp_valid = model_q[0].done; // Oldest entry decides
    exp_full = (count_done() == `DQ_DEPTH);
    check_count++;
    if (alloc_tag !== model_tail) report_mismatch("tags", 64'(model_tail), 64'(alloc_tag));
    check_count++;
    if (commit_valid !== exp_valid) begin
      report_mismatch("commit order valid", 64'(exp_valid), 64'(commit_valid));
    end
    if (exp_valid && commit_valid) begin
      check_count++;
      if (commit.physical !== model_q[0].pair.physical) begin
        report_mismatch("commit order register", 64'(model_q[0].pair.physical),
                        64'(commit.physical));
      end
      check_count++;
      if (commit.data !== model_q[0].data) begin
        report_mismatch("commit order data", 64'(model_q[0].data), 64'(commit.data));
      end
    end
    check_count++;
    if (dq_full !== exp_full) report_mismatch("queue full", 64'(exp_full), 64'(dq_full));
    check_count++;
    if (flush_busy !== 1'b0 || restore_valid !== 1'b0) begin
      report_mismatch("flush idle", 64'(0), 64'({flush_busy, restore_valid}));
    end
  endtask

  // One cycle of random traffic, the model moves with what is driven
  task automatic drive_random_cycle(input int cycle);
    int unsigned  r;
    int unsigned  ack_rate;
    int           open_idx[$];
    int           pick;
    logic         head_done;
    model_entry_t entry;
    add_mapping = 1'b0;
    wb_valid    = 1'b0;
    commit_ack  = 1'b0;
    head_done   = 1'b0;
    if (model_q.size() > 0) head_done = model_q[0].done; // State before this edge
    // Write-back to any entry still waiting, out of program order
    r = $random(seed);
    if (!dq_full && count_done() < `DQ_DEPTH && (r % 100) < 60) begin
      foreach (model_q[i]) begin
        if (!model_q[i].done) open_idx.push_back(i);
      end
      if (open_idx.size() > 0) begin
        r = $random(seed);
        pick = open_idx[r % open_idx.size()];
        entry = model_q[pick];
        r = $random(seed);
        entry.done = 1'b1;
        entry.data = r;
        model_q[pick] = entry;
        wb_valid = 1'b1;
        wb_result.tag  = entry.tag;
        wb_result.data = entry.data;
      end
    end
    // Slow and fast commit phases so the result queue fills up now and then
    ack_rate = ((cycle / 300) % 2 == 0) ? 15 : 80;
    r = $random(seed);
    if (commit_valid && head_done && (r % 100) < ack_rate) begin
      commit_ack = 1'b1;
      entry = model_q.pop_front(); // Head retires at the coming edge
      model_head++;
    end
    r = $random(seed);
    if (model_q.size() < `AL_DEPTH && (r % 100) < 50) begin
      r = $random(seed);
      entry.tag           = model_tail;
      entry.pair.logical  = reg_addr_t'(r);
      entry.pair.physical = reg_addr_t'(r >> 8);
      entry.done          = 1'b0;
      entry.data          = '0;
      model_q.push_back(entry);
      model_tail++;
      add_mapping = 1'b1;
      alloc_pair  = entry.pair;
    end
  endtask

  // Pulse flush, then follow the walk until flush_busy drops
  task automatic run_flush();
    int        i;
    int        waited;
    int        restored;
    int        expected_count;
    map_pair_t exp_pair;
    restore_q.delete();
    for (i = model_q.size() - 1; i >= 0; i--) begin
      restore_q.push_back(model_q[i].pair); // Newest first
    end
    expected_count = restore_q.size();
    model_q.delete();
    model_tail = model_head; // Tail ends up back at the head
    flush_count++;
    add_mapping = 1'b0;
    wb_valid    = 1'b0;
    commit_ack  = 1'b0;
    flush       = 1'b1;
    @(posedge clk);
    #5;
    flush = 1'b0;
    check_count++;
    if (flush_busy !== 1'b1) report_mismatch("flush busy", 64'(1), 64'(flush_busy));
    waited   = 0;
    restored = 0;
    while (flush_busy === 1'b1 && waited < WALK_TIMEOUT) begin
      check_count++;
      if (commit_valid !== 1'b0) report_mismatch("flush commit", 64'(0), 64'(commit_valid));
      if (restore_valid === 1'b1) begin
        if (restore_q.size() == 0) begin
          error_count++;
          $display("Extra restore strobe beyond the %0d uncommitted entries", expected_count);
        end else begin
          exp_pair = restore_q.pop_front();
          check_count++;
          if (restore_pair !== exp_pair) begin
            report_mismatch("flush restore", 64'(exp_pair), 64'(restore_pair));
          end
        end
        restored++;
      end
      @(posedge clk);
      #5;
      waited++;
    end
    if (flush_busy === 1'b1) begin
      error_count++;
      timed_out = 1'b1;
      $display("Timeout: flush_busy still high after %0d cycles", waited);
    end
    check_count++;
    if (restored != expected_count) begin
      report_mismatch("flush count", 64'(expected_count), 64'(restored));
    end
    check_count++;
    if (waited != expected_count + 1) begin
      report_mismatch("flush length", 64'(expected_count + 1), 64'(waited));
    end
  endtask

  initial begin
    int          cycle;
    int unsigned r;
    seed        = 66;
    error_count = 0;
    check_count = 0;
    flush_count = 0;
    timed_out   = 1'b0;
    model_head  = '0;
    model_tail  = '0;
    rst_n       = 1'b0;
    add_mapping = 1'b0;
    alloc_pair  = '0;
    wb_valid    = 1'b0;
    wb_result   = '0;
    commit_ack  = 1'b0;
    flush       = 1'b0;
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;
    check_count++;
    if ({commit_valid, restore_valid, flush_busy, dq_full} !== 4'b0000) begin
      report_mismatch("reset", 64'(0), 64'({commit_valid, restore_valid, flush_busy, dq_full}));
    end
    check_count++;
    if (alloc_tag !== '0) report_mismatch("reset tag", 64'(0), 64'(alloc_tag));
    cycle = 0;
    while (cycle < NUM_CYCLES && !timed_out) begin
      @(posedge clk);
      #5;
      check_outputs();
      r = $random(seed);
      if (cycle > 20 && (r % 1000) < 15) begin
        run_flush(); // Rare, so the list gets a chance to fill between flushes
      end else begin
        drive_random_cycle(cycle);
      end
      cycle++;
    end
    $display("Checks: %0d, errors: %0d, flushes: %0d", check_count, error_count, flush_count);
    if (error_count == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+source
source/active_list_pkg.sv
source/slot_encoder.sv
source/result_queue.sv
source/mapping_table.sv
source/active_list.sv
verification/active_list_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the active list testbench with Verilator, run it and scan the log

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module active_list_tb \
  -o active_list_sim \
  && ./obj_dir/active_list_sim > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "PASS: all tests" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
